// File: verilog/mdu_iq_pkg.sv
package mdu_iq_pkg;

// ----------------------------------------------------------------------
// sizes
localparam int IQ_SIZE  = 4;
localparam int AGE_W    = 3;
localparam int XLEN     = 32;
localparam int ROB_ID_W = 5;
// free-entry count must reach IQ_SIZE itself
localparam int FREE_W   = $clog2(IQ_SIZE + 1);

// ----------------------------------------------------------------------
// encodings
// bit 2 set means the divider path
typedef enum logic [2:0] {
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM,    OP_REMU
} mdu_op_e;

typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
} div_state_e;

// ----------------------------------------------------------------------
// bundles
typedef struct packed {
    logic                rdy;
    logic [ROB_ID_W-1:0] tag;
    logic [XLEN-1:0]     value;
} src_t;

typedef struct packed {
    mdu_op_e             op;
    logic [ROB_ID_W-1:0] rob_id;
    src_t                src1;
    src_t                src2;
} mdu_inst_t;

typedef struct packed {
    logic                valid;
    logic [ROB_ID_W-1:0] tag;
    logic [XLEN-1:0]     data;
} wkup_t;

typedef struct packed {
    mdu_op_e             op;
    logic [ROB_ID_W-1:0] rob_id;
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
} mdu_req_t;

typedef struct packed {
    logic                valid;
    logic [ROB_ID_W-1:0] rob_id;
    logic [XLEN-1:0]     data;
} mdu_res_t;

function automatic logic is_div_op(mdu_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
endfunction

// a waiting source picks up any broadcast carrying its tag
function automatic src_t wake_src(src_t s, wkup_t [2:0] w);
    src_t r;
    r = s;
    for (int k = 0; k < 3; k++) begin
        if (!r.rdy && w[k].valid && w[k].tag == s.tag) begin
            r.rdy   = 1'b1;
            r.value = w[k].data;
        end
    end
    return r;
endfunction

endpackage

// File: verilog/mdu_dispatch.sv
module mdu_dispatch import mdu_iq_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            flush_i,

    input  logic [1:0]      p_valid_i,
    input  mdu_inst_t [1:0] p_inst_i,
    input  wkup_t [2:0]     wkup_i,
    input  logic            issue_pulse_i,

    output logic            iq_ready_o,
    output logic [1:0]      disp_valid_o,
    output mdu_inst_t [1:0] disp_inst_o
);

logic [FREE_W-1:0] free_cnt_q;
logic [FREE_W-1:0] free_cnt_d;
logic              iq_ready_q;
mdu_inst_t [1:0]   woke_inst;

// ----------------------------------------------------------------------
// same-cycle wakeup, so a broadcast is not lost in the register
always_comb begin
    for (int k = 0; k < 2; k++) begin
        woke_inst[k]      = p_inst_i[k];
        woke_inst[k].src1 = wake_src(p_inst_i[k].src1, wkup_i);
        woke_inst[k].src2 = wake_src(p_inst_i[k].src2, wkup_i);
    end
end

always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        disp_valid_o <= '0;
    end else begin
        disp_valid_o <= p_valid_i;
    end
end

always_ff @(posedge clk) begin
    disp_inst_o <= woke_inst;
end

// ----------------------------------------------------------------------
// free entries, counted down on accept and up on issue
assign free_cnt_d = free_cnt_q - FREE_W'(p_valid_i[0]) - FREE_W'(p_valid_i[1])
                  + FREE_W'(issue_pulse_i);

always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        free_cnt_q <= FREE_W'(IQ_SIZE);
        iq_ready_q <= 1'b0;
    end else begin
        free_cnt_q <= free_cnt_d;
        iq_ready_q <= free_cnt_d >= FREE_W'(2);
    end
end

assign iq_ready_o = iq_ready_q;

// outside may only send while two entries are known free
a_no_accept_when_full: assert property (
    @(posedge clk) disable iff (rst_i) |p_valid_i |-> iq_ready_o
);

endmodule

// File: verilog/iq_entry.sv
module iq_entry import mdu_iq_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        flush_i,

    input  logic        write_i,
    input  mdu_inst_t   inst_i,
    input  wkup_t [2:0] wkup_i,
    input  logic        issue_i,

    output logic        busy_o,
    output logic        ready_o,
    output mdu_inst_t   inst_o
);

logic      busy_q;
mdu_inst_t inst_q;
mdu_inst_t inst_base;
mdu_inst_t inst_d;

// ----------------------------------------------------------------------
// occupancy
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        busy_q <= 1'b0;
    end else if (write_i) begin
        busy_q <= 1'b1;
    end else if (issue_i) begin
        busy_q <= 1'b0;
    end
end

// ----------------------------------------------------------------------
// payload, with wakeup applied on write and while waiting
always_comb begin
    inst_base   = write_i ? inst_i : inst_q;
    inst_d      = inst_base;
    inst_d.src1 = wake_src(inst_base.src1, wkup_i);
    inst_d.src2 = wake_src(inst_base.src2, wkup_i);
end

always_ff @(posedge clk) begin
    inst_q <= inst_d;
end

assign busy_o  = busy_q;
assign ready_o = busy_q && inst_q.src1.rdy && inst_q.src2.rdy;
assign inst_o  = inst_q;

// steering in the queue only targets free entries
a_write_free_only: assert property (
    @(posedge clk) disable iff (rst_i) write_i |-> !busy_q
);

endmodule

// File: verilog/mdu_issue_queue.sv
module mdu_issue_queue import mdu_iq_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            flush_i,

    input  logic [1:0]      disp_valid_i,
    input  mdu_inst_t [1:0] disp_inst_i,
    input  wkup_t [2:0]     wkup_i,

    input  logic            mul_ready_i,
    input  logic            div_ready_i,

    output logic            issue_valid_o,
    output mdu_req_t        issue_req_o
);

logic [IQ_SIZE-1:0]            busy;
logic [IQ_SIZE-1:0]            ready;
logic [IQ_SIZE-1:0]            elig;
logic [IQ_SIZE-1:0]            write;
logic [IQ_SIZE-1:0]            wsel;
logic [IQ_SIZE-1:0]            sel;
mdu_inst_t [IQ_SIZE-1:0]       inst;
logic [IQ_SIZE-1:0][AGE_W-1:0] age_q;
logic [IQ_SIZE-1:0][AGE_W:0]   key;
logic [1:0]                    win_lo;
logic [1:0]                    win_hi;
logic [1:0]                    win;
logic                          issue_valid_q;
mdu_req_t                      issue_req_q;

// ----------------------------------------------------------------------
// steering into the lowest free entries
always_comb begin
    logic [IQ_SIZE-1:0] taken;
    logic               placed;
    taken = busy;
    write = '0;
    wsel  = '0;
    for (int k = 0; k < 2; k++) begin
        placed = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (disp_valid_i[k] && !placed && !taken[i]) begin
                write[i] = 1'b1;
                wsel[i]  = k[0];
                taken[i] = 1'b1;
                placed   = 1'b1;
            end
        end
    end
end

for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
    iq_entry u_entry (
        .clk,
        .rst_i,
        .flush_i,
        .write_i (write[i]),
        .inst_i  (disp_inst_i[wsel[i]]),
        .wkup_i,
        .issue_i (sel[i]),
        .busy_o  (busy[i]),
        .ready_o (ready[i]),
        .inst_o  (inst[i])
    );
end

// ----------------------------------------------------------------------
// aging, a thermometer that fills while the entry waits
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        age_q <= '0;
    end else begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (sel[i] || !ready[i]) begin
                age_q[i] <= '0;
            end else begin
                age_q[i] <= {age_q[i][AGE_W-2:0], 1'b1};
            end
        end
    end
end

// ----------------------------------------------------------------------
// oldest eligible entry, lower index on ties
always_comb begin
    for (int i = 0; i < IQ_SIZE; i++) begin
        elig[i] = ready[i] && (is_div_op(inst[i].op) ? div_ready_i : mul_ready_i);
        key[i]  = {elig[i], age_q[i]};
    end
    win_lo   = (key[1] > key[0]) ? 2'd1 : 2'd0;
    win_hi   = (key[3] > key[2]) ? 2'd3 : 2'd2;
    win      = (key[win_hi] > key[win_lo]) ? win_hi : win_lo;
    sel      = '0;
    sel[win] = elig[win];
end

always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        issue_valid_q <= 1'b0;
    end else begin
        issue_valid_q <= |sel;
    end
end

always_ff @(posedge clk) begin
    issue_req_q <= '{op:     inst[win].op,
                     rob_id: inst[win].rob_id,
                     a:      inst[win].src1.value,
                     b:      inst[win].src2.value};
end

assign issue_valid_o = issue_valid_q;
assign issue_req_o   = issue_req_q;

// the tree lands on an eligible entry no younger than any other
for (genvar i = 0; i < IQ_SIZE; i++) begin : g_oldest
    a_sel_oldest: assert property (
        @(posedge clk) disable iff (rst_i)
        elig[i] |-> sel[win] && (age_q[i] < age_q[win] ||
                                 (age_q[i] == age_q[win] && i >= win))
    );
end

endmodule

// File: verilog/e_mdu.sv
module e_mdu import mdu_iq_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     flush_i,

    input  logic     req_valid_i,
    input  mdu_req_t req_i,

    output logic     mul_ready_o,
    output logic     div_ready_o,
    output mdu_res_t res_o
);

logic                       mul_go;
logic                       div_go;
logic                       div_signed;

logic                       s1_valid_q;
logic                       s2_valid_q;
logic                       s1_high_q;
logic                       s2_high_q;
logic [ROB_ID_W-1:0]        s1_rob_q;
logic [ROB_ID_W-1:0]        s2_rob_q;
logic signed [XLEN:0]       s1_a_q;
logic signed [XLEN:0]       s1_b_q;
logic [2*XLEN-1:0]          s2_prod_q;

div_state_e                 div_state_q;
logic [$clog2(XLEN)-1:0]    div_cnt_q;
logic [XLEN:0]              div_rem_q;
logic [XLEN:0]              rem_sh;
logic [XLEN-1:0]            div_quo_q;
logic [XLEN-1:0]            div_dsr_q;
logic [XLEN-1:0]            div_dvd_q;
logic                       div_negq_q;
logic                       div_negr_q;
logic                       div_is_rem_q;
logic                       div_zero_q;
logic [ROB_ID_W-1:0]        div_rob_q;
logic [XLEN-1:0]            div_q_fix;
logic [XLEN-1:0]            div_r_fix;
logic [XLEN-1:0]            div_result;

logic                       res_valid_q;
logic [ROB_ID_W-1:0]        res_rob_q;
logic [XLEN-1:0]            res_data_q;

assign mul_go     = req_valid_i && !is_div_op(req_i.op);
assign div_go     = req_valid_i && is_div_op(req_i.op);
assign div_signed = req_i.op inside {OP_DIV, OP_REM};

// a pending request counts as in flight for both levels
assign div_ready_o = (div_state_q == DIV_IDLE) && !req_valid_i && !s1_valid_q && !s2_valid_q;
assign mul_ready_o = (div_state_q == DIV_IDLE) && !div_go;

// ----------------------------------------------------------------------
// multiply: operands, product, result register
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        s1_valid_q <= 1'b0;
        s2_valid_q <= 1'b0;
    end else begin
        s1_valid_q <= mul_go;
        s2_valid_q <= s1_valid_q;
    end
end

always_ff @(posedge clk) begin
    // sign extension per variant
    s1_a_q    <= {(req_i.op inside {OP_MULH, OP_MULHSU}) & req_i.a[XLEN-1], req_i.a};
    s1_b_q    <= {(req_i.op == OP_MULH) & req_i.b[XLEN-1], req_i.b};
    s1_high_q <= req_i.op != OP_MUL;
    s1_rob_q  <= req_i.rob_id;
    s2_prod_q <= s1_a_q * s1_b_q;
    s2_high_q <= s1_high_q;
    s2_rob_q  <= s1_rob_q;
end

// ----------------------------------------------------------------------
// divide: restoring, one quotient bit per cycle
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        div_state_q <= DIV_IDLE;
        div_cnt_q   <= '0;
    end else begin
        case (div_state_q)
            DIV_IDLE: begin
                if (div_go) begin
                    div_state_q <= DIV_BUSY;
                    div_cnt_q   <= '0;
                end
            end
            DIV_BUSY: begin
                div_cnt_q <= div_cnt_q + 1'b1;
                if (div_cnt_q == $clog2(XLEN)'(XLEN - 1)) begin
                    div_state_q <= DIV_DONE;
                end
            end
            default: div_state_q <= DIV_IDLE;
        endcase
    end
end

assign rem_sh = {div_rem_q[XLEN-1:0], div_quo_q[XLEN-1]};

always_ff @(posedge clk) begin
    if (div_state_q == DIV_IDLE && div_go) begin
        // work on magnitudes, signs fixed at the end
        div_quo_q    <= (div_signed && req_i.a[XLEN-1]) ? -req_i.a : req_i.a;
        div_dsr_q    <= (div_signed && req_i.b[XLEN-1]) ? -req_i.b : req_i.b;
        div_rem_q    <= '0;
        div_dvd_q    <= req_i.a;
        div_zero_q   <= req_i.b == '0;
        div_negq_q   <= div_signed && (req_i.a[XLEN-1] ^ req_i.b[XLEN-1]);
        div_negr_q   <= div_signed && req_i.a[XLEN-1];
        div_is_rem_q <= req_i.op inside {OP_REM, OP_REMU};
        div_rob_q    <= req_i.rob_id;
    end else if (div_state_q == DIV_BUSY) begin
        if (rem_sh >= {1'b0, div_dsr_q}) begin
            div_rem_q <= rem_sh - {1'b0, div_dsr_q};
            div_quo_q <= {div_quo_q[XLEN-2:0], 1'b1};
        end else begin
            div_rem_q <= rem_sh;
            div_quo_q <= {div_quo_q[XLEN-2:0], 1'b0};
        end
    end
end

// min / -1 falls out of the magnitude path, only x / 0 needs a case
always_comb begin
    div_q_fix = div_negq_q ? -div_quo_q : div_quo_q;
    div_r_fix = div_negr_q ? -div_rem_q[XLEN-1:0] : div_rem_q[XLEN-1:0];
    if (div_zero_q) begin
        div_result = div_is_rem_q ? div_dvd_q : '1;
    end else begin
        div_result = div_is_rem_q ? div_r_fix : div_q_fix;
    end
end

// ----------------------------------------------------------------------
// result merge
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        res_valid_q <= 1'b0;
    end else begin
        res_valid_q <= s2_valid_q || (div_state_q == DIV_DONE);
    end
end

always_ff @(posedge clk) begin
    if (s2_valid_q) begin
        res_rob_q  <= s2_rob_q;
        res_data_q <= s2_high_q ? s2_prod_q[2*XLEN-1:XLEN] : s2_prod_q[XLEN-1:0];
    end else begin
        res_rob_q  <= div_rob_q;
        res_data_q <= div_result;
    end
end

assign res_o = '{valid: res_valid_q, rob_id: res_rob_q, data: res_data_q};

// ready gating in the queue keeps the two paths apart
a_no_result_clash: assert property (
    @(posedge clk) disable iff (rst_i) !(s2_valid_q && div_state_q == DIV_DONE)
);

endmodule

// File: verilog/mdu_iq_top.sv
module mdu_iq_top import mdu_iq_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            flush_i,

    input  logic [1:0]      p_valid_i,
    input  mdu_inst_t [1:0] p_inst_i,
    output logic            iq_ready_o,

    input  wkup_t [1:0]     cdb_i,
    output mdu_res_t        result_o
);

wkup_t [2:0]     wkup_all;
logic [1:0]      disp_valid;
mdu_inst_t [1:0] disp_inst;
logic            issue_valid;
mdu_req_t        issue_req;
logic            mul_ready;
logic            div_ready;

// own results go back into the queue as a third broadcast
assign wkup_all[0] = cdb_i[0];
assign wkup_all[1] = cdb_i[1];
assign wkup_all[2] = '{valid: result_o.valid, tag: result_o.rob_id, data: result_o.data};

mdu_dispatch u_dispatch (
    .clk,
    .rst_i,
    .flush_i,
    .p_valid_i,
    .p_inst_i,
    .wkup_i        (wkup_all),
    .issue_pulse_i (issue_valid),
    .iq_ready_o,
    .disp_valid_o  (disp_valid),
    .disp_inst_o   (disp_inst)
);

mdu_issue_queue u_queue (
    .clk,
    .rst_i,
    .flush_i,
    .disp_valid_i  (disp_valid),
    .disp_inst_i   (disp_inst),
    .wkup_i        (wkup_all),
    .mul_ready_i   (mul_ready),
    .div_ready_i   (div_ready),
    .issue_valid_o (issue_valid),
    .issue_req_o   (issue_req)
);

e_mdu u_mdu (
    .clk,
    .rst_i,
    .flush_i,
    .req_valid_i   (issue_valid),
    .req_i         (issue_req),
    .mul_ready_o   (mul_ready),
    .div_ready_o   (div_ready),
    .res_o         (result_o)
);

endmodule

// File: testbench/mdu_iq_tb.sv
module mdu_iq_tb import mdu_iq_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int N_STREAM    = 80;
localparam int N_PRE_FLUSH = 20;
localparam int N_TOTAL     = 2 * N_STREAM + N_PRE_FLUSH;
localparam int TIMEOUT_NS  = (40 * N_TOTAL + 200) * 10;

logic            clk;
logic            rst_i;
logic            flush_i;
logic [1:0]      p_valid_i;
mdu_inst_t [1:0] p_inst_i;
logic            iq_ready_o;
wkup_t [1:0]     cdb_i;
mdu_res_t        result_o;

// ----------------------------------------------------------------------
// reference model state, indexed by rob id
bit          used [32];
bit          is_ext [32];
mdu_op_e     op_m [32];
logic [31:0] val_m [32][2];
bit          wait_m [32][2];
logic [4:0]  tag_m [32][2];
int          ext_delay [32];
logic [31:0] ext_val [32];

int         seed;
int         free_m;
bit         rdy_m;
logic       ready_seen;
int         errors;
int         checks;
int         n_results;
int         n_sent;
int         n_quota;
int         n_ext_pending;
int         n_low;
logic [4:0] next_id;

mdu_iq_top DUT (
    .clk,
    .rst_i,
    .flush_i,
    .p_valid_i,
    .p_inst_i,
    .iq_ready_o,
    .cdb_i,
    .result_o
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

initial begin
    #(TIMEOUT_NS);
    $display("timeout: results still missing after %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
end

function automatic int rnd(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
endfunction

// corner values show up often, x / 0 among them
function automatic logic [31:0] rand_value();
    case (rnd(8))
        0:       return 32'h0;
        1:       return 32'h8000_0000;
        2:       return 32'hffff_ffff;
        3:       return 32'h1;
        default: return $random(seed);
    endcase
endfunction

function automatic logic [31:0] ref_result(mdu_op_e opv, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        p;
    logic signed [31:0] sres;
    bit                 ovf;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'b0, a};
    ub  = {32'b0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (opv)
        OP_MUL: begin
            p = ua * ub;
            return p[31:0];
        end
        OP_MULH: begin
            p = sa * sb;
            return p[63:32];
        end
        OP_MULHSU: begin
            p = sa * $signed(ub);
            return p[63:32];
        end
        OP_MULHU: begin
            p = ua * ub;
            return p[63:32];
        end
        OP_DIV: begin
            if (b == 0) begin
                return 32'hffff_ffff;
            end
            if (ovf) begin
                return a;
            end
            sres = $signed(a) / $signed(b);
            return sres;
        end
        OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
        OP_REM: begin
            if (b == 0) begin
                return a;
            end
            if (ovf) begin
                return 32'h0;
            end
            sres = $signed(a) % $signed(b);
            return sres;
        end
        default: return (b == 0) ? a : a % b;
    endcase
endfunction

// a broadcast fills every waiting source with that tag
task automatic resolve(logic [4:0] id, logic [31:0] v);
    for (int j = 0; j < 32; j++) begin
        for (int s = 0; s < 2; s++) begin
            if (used[j] && !is_ext[j] && wait_m[j][s] && tag_m[j][s] == id) begin
                wait_m[j][s] = 1'b0;
                val_m[j][s]  = v;
            end
        end
    end
endtask

task automatic alloc(output logic [4:0] id, output bit found);
    logic [4:0] cand;
    found = 1'b0;
    id    = '0;
    for (int i = 0; i < 32; i++) begin
        cand = next_id + 5'(i);
        if (!found && !used[cand]) begin
            id    = cand;
            found = 1'b1;
        end
    end
    if (found) begin
        next_id = id + 5'd1;
    end
endtask

// ----------------------------------------------------------------------
// stimulus
task automatic make_src(input logic [4:0] self, output src_t s);
    int         c;
    int         k;
    logic [4:0] id;
    bit         found;
    found   = 1'b0;
    s.rdy   = 1'b1;
    s.tag   = '0;
    s.value = rand_value();
    c       = rnd(4);
    if (c == 0 && n_ext_pending < 4) begin
        // new outside producer, broadcast later on cdb_i
        alloc(id, found);
        if (found) begin
            used[id]      = 1'b1;
            is_ext[id]    = 1'b1;
            ext_delay[id] = rnd(12) + 1;
            ext_val[id]   = $random(seed);
            n_ext_pending++;
        end
    end else if (c == 1) begin
        k = rnd(32);
        for (int i = 0; i < 32; i++) begin
            if (!found && used[5'(k + i)] && !is_ext[5'(k + i)] && 5'(k + i) != self) begin
                id    = 5'(k + i);
                found = 1'b1;
            end
        end
    end
    if (found) begin
        s.rdy   = 1'b0;
        s.tag   = id;
        s.value = '0;
    end
endtask

task automatic plan_inst(output mdu_inst_t inst, output bit ok);
    logic [4:0] id;
    mdu_op_e    opv;
    src_t       s1;
    src_t       s2;
    inst = '0;
    alloc(id, ok);
    if (!ok) begin
        return;
    end
    used[id]   = 1'b1;
    is_ext[id] = 1'b0;
    opv        = mdu_op_e'(rnd(8));
    make_src(id, s1);
    make_src(id, s2);
    if (opv inside {OP_DIV, OP_REM} && rnd(6) == 0) begin
        s1 = '{rdy: 1'b1, tag: '0, value: 32'h8000_0000};
        s2 = '{rdy: 1'b1, tag: '0, value: 32'hffff_ffff};
    end
    op_m[id]      = opv;
    wait_m[id][0] = !s1.rdy;
    wait_m[id][1] = !s2.rdy;
    tag_m[id][0]  = s1.tag;
    tag_m[id][1]  = s2.tag;
    val_m[id][0]  = s1.value;
    val_m[id][1]  = s2.value;
    inst = '{op: opv, rob_id: id, src1: s1, src2: s2};
endtask

// ----------------------------------------------------------------------
// checks
task automatic check_result();
    logic [4:0]  id;
    logic [31:0] exp;
    if (!result_o.valid) begin
        return;
    end
    id = result_o.rob_id;
    checks++;
    if (!used[id] || is_ext[id]) begin
        errors++;
        $display("%0t: result for rob id %0d, which is unknown or already done", $time, id);
        return;
    end
    exp = result_o.data;
    if (wait_m[id][0] || wait_m[id][1]) begin
        errors++;
        $display("%0t: rob id %0d completed before its operands were broadcast", $time, id);
    end else begin
        exp = ref_result(op_m[id], val_m[id][0], val_m[id][1]);
        if (result_o.data !== exp) begin
            errors++;
            $display("[FAIL] %0t result_o.data rob %0d %s: expected %h, got %h",
                     $time, id, op_m[id].name(), exp, result_o.data);
        end
    end
    used[id] = 1'b0;
    n_results++;
    resolve(id, exp);
endtask

// free-count rule, predicts iq_ready_o for the next cycle
task automatic check_ready();
    checks++;
    ready_seen = iq_ready_o;
    if (iq_ready_o !== rdy_m) begin
        errors++;
        $display("[FAIL] %0t iq_ready_o: expected %b, got %b", $time, rdy_m, iq_ready_o);
    end
    if (!iq_ready_o) begin
        n_low++;
    end
    if (rst_i || flush_i) begin
        free_m = IQ_SIZE;
        rdy_m  = 1'b0;
    end else begin
        free_m = free_m - int'(p_valid_i[0]) - int'(p_valid_i[1]) + int'(DUT.issue_valid);
        rdy_m  = free_m >= 2;
    end
endtask

// ----------------------------------------------------------------------
// one clock: sample at the falling edge, drive at the rising edge
task automatic run_cycle(bit allow_new, bit do_flush);
    logic [1:0]      pv;
    mdu_inst_t [1:0] pi;
    wkup_t [1:0]     cd;
    int              nb;
    int              want;
    bit              ok;
    @(negedge clk);
    check_result();
    check_ready();
    pv = '0;
    pi = '0;
    cd = '0;
    nb = 0;
    for (int i = 0; i < 32; i++) begin
        if (used[i] && is_ext[i]) begin
            if (ext_delay[i] > 0) begin
                ext_delay[i]--;
            end
            if (ext_delay[i] == 0 && nb < 2) begin
                cd[nb] = '{valid: 1'b1, tag: 5'(i), data: ext_val[i]};
                nb++;
                used[i] = 1'b0;
                n_ext_pending--;
                resolve(5'(i), ext_val[i]);
            end
        end
    end
    if (allow_new && !do_flush && rdy_m) begin
        want = rnd(3);
        for (int k = 0; k < want; k++) begin
            if (n_sent < n_quota) begin
                plan_inst(pi[k], ok);
                if (ok) begin
                    pv[k] = 1'b1;
                    n_sent++;
                end
            end
        end
    end
    @(posedge clk);
    p_valid_i <= pv;
    p_inst_i  <= pi;
    cdb_i     <= cd;
    flush_i   <= do_flush;
endtask

function automatic int count_mdu();
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
        if (used[i] && !is_ext[i]) begin
            n++;
        end
    end
    return n;
endfunction

task automatic drain();
    int guard;
    guard = 0;
    while ((count_mdu() > 0 || n_ext_pending > 0) && guard < 600) begin
        run_cycle(1'b0, 1'b0);
        guard++;
    end
    for (int i = 0; i < 32; i++) begin
        if (used[i] && !is_ext[i]) begin
            errors++;
            $display("%0t: rob id %0d was accepted but never completed", $time, i);
        end
        used[i] = 1'b0;
    end
    n_ext_pending = 0;
endtask

task automatic run_stream(string name, int count);
    int e0;
    int r0;
    e0      = errors;
    r0      = n_results;
    n_sent  = 0;
    n_quota = count;
    while (n_sent < count) begin
        run_cycle(1'b1, 1'b0);
    end
    drain();
    $display("test %s: %0d sent, %0d results, %0d errors",
             name, n_sent, n_results - r0, errors - e0);
endtask

task automatic flush_test();
    int e0;
    e0      = errors;
    n_sent  = 0;
    n_quota = N_PRE_FLUSH;
    while (n_sent < N_PRE_FLUSH) begin
        run_cycle(1'b1, 1'b0);
    end
    run_cycle(1'b0, 1'b1);
    // results in the flush cycle itself are still legal
    run_cycle(1'b0, 1'b0);
    for (int i = 0; i < 32; i++) begin
        used[i] = 1'b0;
    end
    n_ext_pending = 0;
    repeat (40) begin
        run_cycle(1'b0, 1'b0);
    end
    checks++;
    if (ready_seen !== 1'b1) begin
        errors++;
        $display("%0t: iq_ready_o did not return high after the flush", $time);
    end
    $display("test flush: %0d sent before flush, %0d errors", n_sent, errors - e0);
endtask

initial begin
    seed          = 32'hd7b1_1b1e;
    rst_i         = 1'b1;
    flush_i       = 1'b0;
    p_valid_i     = '0;
    p_inst_i      = '0;
    cdb_i         = '0;
    free_m        = IQ_SIZE;
    rdy_m         = 1'b0;
    ready_seen    = 1'b0;
    errors        = 0;
    checks        = 0;
    n_results     = 0;
    n_ext_pending = 0;
    n_low         = 0;
    next_id       = '0;
    for (int i = 0; i < 32; i++) begin
        used[i]   = 1'b0;
        is_ext[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;

    run_stream("random mix", N_STREAM);
    flush_test();
    run_stream("after flush", N_STREAM);

    $display("checks %0d, errors %0d, results %0d, cycles with iq_ready_o low %0d",
             checks, errors, n_results, n_low);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule

// File: all.f
verilog/mdu_iq_pkg.sv
verilog/mdu_dispatch.sv
verilog/iq_entry.sv
verilog/mdu_issue_queue.sv
verilog/e_mdu.sv
verilog/mdu_iq_top.sv
testbench/mdu_iq_tb.sv
